/* rx_access_detect.f */
+incdir+include
verilog/bt_rx_pkg.sv
verilog/rx_bit_sampler.sv
verilog/sync_correlator.sv
verilog/code_select.sv
verilog/rx_access_detect.sv
tb/tb_rx_access_detect.sv

/* include/tb_rx_access_tasks.svh */
`ifndef TB_RX_ACCESS_TASKS_SVH
`define TB_RX_ACCESS_TASKS_SVH

// shared random source, one step per bit taken
logic [31:0] lfsr_state;

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

function automatic int count_ones(input bt_rx_pkg::sync_word_t v);
  int n;
  n = 0;
  for (int b = 0; b < bt_rx_pkg::SYNC_BITS; b++)
    n += int'(v[b]);
  return n;
endfunction

task automatic lfsr_init();
  lfsr_state = 32'd71401;
endtask

task automatic rand_bit(output logic b);
  lfsr_state = lfsr_step(lfsr_state);
  b = lfsr_state[0];
endtask

task automatic rand_word(output bt_rx_pkg::sync_word_t w);
  logic b;
  for (int i = 0; i < bt_rx_pkg::SYNC_BITS; i++)
  begin
    rand_bit(b);
    w[i] = b;
  end
endtask

// bit is held across the next tick, changed after the falling edge
task automatic send_bit(input logic b);
  rxsymbol = {2'b00, b};
  @(posedge clk_6M iff p_1us);
  @(negedge clk_6M);
endtask

// msb goes out first
task automatic send_word(input bt_rx_pkg::sync_word_t w);
  for (int i = bt_rx_pkg::SYNC_BITS - 1; i >= 0; i--)
    send_bit(w[i]);
endtask

task automatic send_filler(input int n);
  logic b;
  for (int i = 0; i < n; i++)
  begin
    rand_bit(b);
    send_bit(b);
  end
endtask

// k distinct flipped positions, six random bits per position
task automatic inject_errors(input bt_rx_pkg::sync_word_t w, input int k,
                             output bt_rx_pkg::sync_word_t corrupted);
  bt_rx_pkg::sync_word_t mask;
  int pos;
  logic b;
  mask = '0;
  while (count_ones(mask) < k)
  begin
    pos = 0;
    for (int j = 0; j < 6; j++)
    begin
      rand_bit(b);
      pos = (pos << 1) | int'(b);
    end
    mask[pos] = 1'b1;
  end
  corrupted = w ^ mask;
endtask

`endif

/* tb/tb_rx_access_detect.sv */
`timescale 1ns/1ps

module tb_rx_access_detect;

  import bt_rx_pkg::*;

  localparam int          HOLDOFF    = 16;
  localparam int          CLK_PERIOD = 8;
  localparam int          TOTAL_BITS = 576;
  localparam int          EXP_TRIGS  = 5;
  localparam logic [7:0]  PAT_BYTE   = 8'hE8;

  logic                         clk_6M;
  logic                         rstz;
  logic [2:0]                   rxsymbol;
  sync_word_t [N_CODES-1:0]     sync_words;
  logic [N_CODES-1:0]           code_enable;
  err_thresh_t                  corre_threshold;
  logic                         p_1us;
  detect_t                      detect;

  `include "tb_rx_access_tasks.svh"

  // reference model state
  logic [31:0] cyc;
  logic        exp_p1us;
  logic        tick_d1;
  sync_word_t  m_window;
  int          hold_left;
  logic        m_trig_a;
  code_idx_t   m_code_a;
  err_count_t  m_err_a;
  logic        exp_trig;
  code_idx_t   exp_code;
  err_count_t  exp_errors;
  int          n_trig;

  rx_access_detect #(
    .HOLDOFF_BITS (HOLDOFF)
  ) uut (
    .clk_6M          (clk_6M),
    .rstz            (rstz),
    .rxsymbol        (rxsymbol),
    .sync_words      (sync_words),
    .code_enable     (code_enable),
    .corre_threshold (corre_threshold),
    .p_1us           (p_1us),
    .detect          (detect)
  );

  initial
  begin
    clk_6M = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk_6M = ~clk_6M;
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping on first error");
  endtask

  // window shifts on the tick, codes are judged one cycle later
  always @(posedge clk_6M or negedge rstz)
  begin : ref_model
    int         cnt;
    logic       found;
    code_idx_t  idx;
    err_count_t idx_err;
    if (!rstz)
    begin
      cyc       <= '0;
      exp_p1us  <= 1'b0;
      tick_d1   <= 1'b0;
      m_window  <= '0;
      hold_left = 0;
      m_trig_a  <= 1'b0;
      exp_trig  <= 1'b0;
    end
    else
    begin
      exp_p1us <= (cyc % TICK_DIV == TICK_DIV - 1);
      cyc      <= cyc + 1;
      tick_d1  <= exp_p1us;
      if (exp_p1us)
        m_window <= {m_window[SYNC_BITS-2:0], rxsymbol[0]};
      m_trig_a <= 1'b0;
      if (tick_d1)
      begin
        found   = 1'b0;
        idx     = '0;
        idx_err = '0;
        for (int i = 0; i < N_CODES; i++)
        begin
          cnt = count_ones(m_window ^ sync_words[i]);
          if (!found && code_enable[i] && cnt <= int'(corre_threshold))
          begin
            found   = 1'b1;
            idx     = code_idx_t'(i);
            idx_err = err_count_t'(cnt);
          end
        end
        if (hold_left > 0)
          hold_left = hold_left - 1;
        else if (found)
        begin
          m_trig_a  <= 1'b1;
          m_code_a  <= idx;
          m_err_a   <= idx_err;
          hold_left = HOLDOFF;
        end
      end
      exp_trig   <= m_trig_a;
      exp_code   <= m_code_a;
      exp_errors <= m_err_a;
    end
  end

  always @(posedge clk_6M)
  begin
    if (rstz && detect.trig)
      n_trig++;
  end

  assert property (@(posedge clk_6M) disable iff (!rstz) p_1us == exp_p1us)
  else
    report_mismatch("p_1us off the 1 us bit grid");

  assert property (@(posedge clk_6M) disable iff (!rstz) detect.trig == exp_trig)
  else
    report_mismatch($sformatf("trig %0b, model %0b", $sampled(detect.trig),
                              $sampled(exp_trig)));

  assert property (@(posedge clk_6M) disable iff (!rstz)
    detect.trig |-> (detect.code == exp_code && detect.errors == exp_errors))
  else
    report_mismatch($sformatf("code %0d errors %0d, model code %0d errors %0d",
                              $sampled(detect.code), $sampled(detect.errors),
                              $sampled(exp_code), $sampled(exp_errors)));

  initial
  begin
    #(TOTAL_BITS * TICK_DIV * CLK_PERIOD + 2000);
    $display("Timeout: the test sequence did not finish in time");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin : stimulus
    sync_word_t w;
    sync_word_t bad;
    rstz            = 1'b0;
    rxsymbol        = 3'b000;
    code_enable     = 4'b0111;
    corre_threshold = 6'd4;
    n_trig          = 0;
    lfsr_init();
    for (int i = 0; i < N_CODES; i++)
    begin
      rand_word(w);
      sync_words[i] = w;
    end
    repeat (4) @(negedge clk_6M);
    rstz = 1'b1;

    send_filler(20);
    // exact DAC
    send_word(sync_words[1]);
    send_filler(20);
    // GIAC with errors inside the threshold
    inject_errors(sync_words[2], 3, bad);
    send_word(bad);
    send_filler(20);
    // CAC with errors over the threshold
    inject_errors(sync_words[0], 6, bad);
    send_word(bad);
    send_filler(20);
    // DIAC is disabled
    send_word(sync_words[3]);
    send_filler(20);
    // equal DAC and GIAC, lower index wins
    sync_words[2] = sync_words[1];
    send_word(sync_words[1]);
    send_filler(20);

    // periodic DIAC repeats every 8 bits to probe the hold-off
    sync_words[3]   = {8{PAT_BYTE}};
    code_enable     = 4'b1111;
    corre_threshold = 6'd0;
    send_filler(20);
    for (int i = 0; i < 8; i++)
      send_bit(~PAT_BYTE[7 - i]);
    send_word(sync_words[3]);
    for (int i = 0; i < 24; i++)
      send_bit(PAT_BYTE[7 - (i % 8)]);
    send_filler(20);

    if (n_trig != EXP_TRIGS)
      report_mismatch($sformatf("saw %0d triggers, expected %0d", n_trig, EXP_TRIGS));
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* verilog/rx_access_detect.sv */
`timescale 1ns/1ps

module rx_access_detect #(
  parameter int HOLDOFF_BITS = 64
) (
  input  logic                                            clk_6M,
  input  logic                                            rstz,
  input  logic [2:0]                                      rxsymbol,
  input  bt_rx_pkg::sync_word_t [bt_rx_pkg::N_CODES-1:0] sync_words,
  input  logic [bt_rx_pkg::N_CODES-1:0]                   code_enable,
  input  bt_rx_pkg::err_thresh_t                          corre_threshold,
  output logic                                            p_1us,
  output bt_rx_pkg::detect_t                              detect
);

  import bt_rx_pkg::*;

  rx_window_t                 window;
  corr_result_t [N_CODES-1:0] results;

  rx_bit_sampler u_sampler (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .rxsymbol (rxsymbol),
    .p_1us    (p_1us),
    .window   (window)
  );

  // CAC, DAC, GIAC, DIAC in index order
  generate
    for (genvar i = 0; i < N_CODES; i++)
    begin : g_corr
      sync_correlator u_corr (
        .clk_6M          (clk_6M),
        .rstz            (rstz),
        .window          (window),
        .sync_word       (sync_words[i]),
        .enable          (code_enable[i]),
        .corre_threshold (corre_threshold),
        .result          (results[i])
      );
    end
  endgenerate

  code_select #(
    .HOLDOFF_BITS (HOLDOFF_BITS)
  ) u_select (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .window_valid (window.valid),
    .results      (results),
    .detect       (detect)
  );

endmodule

/* verilog/code_select.sv */
`timescale 1ns/1ps

module code_select #(
  parameter int HOLDOFF_BITS = 64
) (
  input  logic                                              clk_6M,
  input  logic                                              rstz,
  input  logic                                              window_valid,
  input  bt_rx_pkg::corr_result_t [bt_rx_pkg::N_CODES-1:0] results,
  output bt_rx_pkg::detect_t                                detect
);

  import bt_rx_pkg::*;

  localparam int HOLD_W = $clog2(HOLDOFF_BITS + 1);

  det_state_t        state;
  logic              valid_d;
  logic [HOLD_W-1:0] hold_cnt;
  logic              any_hit;
  code_idx_t         pick_idx;
  err_count_t        pick_err;
  logic              fire;
  logic              trig_q;
  code_idx_t         code_q;
  err_count_t        errors_q;

  // lowest index wins, so scan downward
  always_comb
  begin
    any_hit  = 1'b0;
    pick_idx = '0;
    pick_err = '0;
    for (int i = N_CODES - 1; i >= 0; i--)
    begin
      if (results[i].hit)
      begin
        any_hit  = 1'b1;
        pick_idx = code_idx_t'(i);
        pick_err = results[i].errors;
      end
    end
  end

  // results are fresh one cycle after the window
  assign fire = (state == DET_ARMED) && valid_d && any_hit;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state    <= DET_ARMED;
      valid_d  <= 1'b0;
      hold_cnt <= '0;
      trig_q   <= 1'b0;
    end
    else
    begin
      valid_d <= window_valid;
      trig_q  <= fire;
      case (state)
        DET_ARMED:
          if (fire)
          begin
            hold_cnt <= '0;
            state    <= DET_HOLD;
          end
        DET_HOLD:
          // the last masked window is dropped as it leaves hold
          if (valid_d && hold_cnt == HOLD_W'(HOLDOFF_BITS))
            state <= DET_ARMED;
          else if (window_valid)
            hold_cnt <= hold_cnt + 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (fire)
    begin
      code_q   <= pick_idx;
      errors_q <= pick_err;
    end
  end

  assign detect = '{trig: trig_q, code: code_q, errors: errors_q};

  assert property (@(posedge clk_6M) disable iff (!rstz)
    detect.trig |=> !detect.trig)
  else
    $error("trigger held for two cycles");

  assert property (@(posedge clk_6M) disable iff (!rstz)
    detect.trig |-> $past(state) == DET_ARMED)
  else
    $error("trigger fired during hold-off");

endmodule

/* verilog/sync_correlator.sv */
`timescale 1ns/1ps

module sync_correlator (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  bt_rx_pkg::rx_window_t   window,
  input  bt_rx_pkg::sync_word_t   sync_word,
  input  logic                    enable,
  input  bt_rx_pkg::err_thresh_t  corre_threshold,
  output bt_rx_pkg::corr_result_t result
);

  import bt_rx_pkg::*;

  err_count_t mismatches;
  logic       hit_q;
  err_count_t errors_q;

  // popcount of the differing bits
  always_comb
  begin
    mismatches = '0;
    for (int b = 0; b < SYNC_BITS; b++)
      mismatches = mismatches + err_count_t'(window.bits[b] ^ sync_word[b]);
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hit_q <= 1'b0;
    else if (window.valid)
      hit_q <= enable && (mismatches <= err_count_t'(corre_threshold));
  end

  // count held with the hit until the next window
  always_ff @(posedge clk_6M)
  begin
    if (window.valid)
      errors_q <= mismatches;
  end

  assign result = '{hit: hit_q, errors: errors_q};

  // threshold as it was when the window was evaluated
  assert property (@(posedge clk_6M) disable iff (!rstz)
    window.valid |=> (!result.hit ||
                      result.errors <= err_count_t'($past(corre_threshold))))
  else
    $error("hit flagged above the error threshold");

endmodule

/* verilog/rx_bit_sampler.sv */
`timescale 1ns/1ps

module rx_bit_sampler (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic [2:0]            rxsymbol,
  output logic                  p_1us,
  output bt_rx_pkg::rx_window_t window
);

  import bt_rx_pkg::*;

  localparam int CNT_W = $clog2(TICK_DIV);

  logic [CNT_W-1:0] tick_cnt;
  logic             tick_last;
  sync_word_t       sync_in;
  logic             win_valid;

  assign tick_last = (tick_cnt == CNT_W'(TICK_DIV - 1));

  // 1 us strobe, first one TICK_DIV cycles out of reset
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tick_cnt <= '0;
      p_1us    <= 1'b0;
    end
    else
    begin
      p_1us <= tick_last;
      if (tick_last)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // newest bit in bit 0, the word arrives msb first
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sync_in   <= '0;
      win_valid <= 1'b0;
    end
    else
    begin
      win_valid <= p_1us;
      if (p_1us)
        sync_in <= {sync_in[SYNC_BITS-2:0], rxsymbol[0]};
    end
  end

  assign window = '{bits: sync_in, valid: win_valid};

  // a window is only ever new right after a bit strobe
  assert property (@(posedge clk_6M) disable iff (!rstz)
    window.valid |-> $past(p_1us))
  else
    $error("window valid without a preceding bit tick");

endmodule

/* verilog/bt_rx_pkg.sv */
package bt_rx_pkg;

  // sync word length in bits
  parameter int SYNC_BITS = 64;

  // 0 CAC, 1 DAC, 2 GIAC, 3 DIAC
  parameter int N_CODES = 4;

  // clk_6M cycles per 1 us bit
  parameter int TICK_DIV = 6;

  typedef logic [SYNC_BITS-1:0] sync_word_t;

  // 0 to 64 mismatches
  typedef logic [6:0] err_count_t;

  typedef logic [5:0] err_thresh_t;

  typedef logic [1:0] code_idx_t;

  // sampler to correlators
  typedef struct packed {
    sync_word_t bits;
    logic       valid;
  } rx_window_t;

  // one per correlator
  typedef struct packed {
    logic       hit;
    err_count_t errors;
  } corr_result_t;

  typedef struct packed {
    logic       trig;
    code_idx_t  code;
    err_count_t errors;
  } detect_t;

  typedef enum logic {
    DET_ARMED,
    DET_HOLD
  } det_state_t;

endpackage
